// ==== common/epu_consts.svh ====
`ifndef EPU_CONSTS_SVH
`define EPU_CONSTS_SVH

// Buffer geometry, one 32-bit word per entry
`define EPU_BUF_DEPTH 256
`define EPU_BUF_AW    8

// Region codes, matched against address bits 31 to 24
`define EPU_REG_IN   8'h50
`define EPU_REG_OUT  8'h60
`define EPU_REG_WT   8'h70
`define EPU_REG_BIAS 8'h71
`define EPU_REG_CTRL 8'h80

// Byte offsets inside the control region
`define EPU_CTRL_LEN  10'h000
`define EPU_CTRL_CMD  10'h004
`define EPU_CTRL_STAT 10'h008

// Every response is OKAY
`define AXI_RESP_OKAY 2'b00

`endif

// ==== common/epu_pkg.sv ====
`include "epu_consts.svh"

package epu_pkg;

    // AXI field widths
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [3:0]  axi_strb_t;

    // Word index into a buffer
    typedef logic [`EPU_BUF_AW-1:0] buf_addr_t;

    // Element count, 0 up to a full buffer
    typedef logic [`EPU_BUF_AW:0] run_len_t;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        W_DATA  = 3'd1,
        B_RESP  = 3'd2,
        R_FETCH = 3'd3,
        R_DATA  = 3'd4
    } slave_state_t;

endpackage

// ==== common/buf_port_if.sv ====
interface buf_port_if
    import epu_pkg::*;
();

    logic      en;
    logic      we;
    axi_strb_t be;
    buf_addr_t addr;
    axi_data_t wdata;
    axi_data_t rdata;

    // Requester side
    modport master (
        output en, we, be, addr, wdata,
        input  rdata
    );

    // Storage side
    modport slave (
        input  en, we, be, addr, wdata,
        output rdata
    );

endinterface

// ==== hw/epu_axi_slave.sv ====
`include "epu_consts.svh"

module epu_axi_slave
    import epu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axi_id_t    awid_i,
    input  axi_addr_t  awaddr_i,
    input  axi_len_t   awlen_i,
    input  logic [1:0] awburst_i,
    input  logic       awvalid_i,
    output logic       awready_o,
    input  axi_data_t  wdata_i,
    input  axi_strb_t  wstrb_i,
    input  logic       wlast_i,
    input  logic       wvalid_i,
    output logic       wready_o,
    output axi_id_t    bid_o,
    output logic [1:0] bresp_o,
    output logic       bvalid_o,
    input  logic       bready_i,
    input  axi_id_t    arid_i,
    input  axi_addr_t  araddr_i,
    input  axi_len_t   arlen_i,
    input  logic [1:0] arburst_i,
    input  logic       arvalid_i,
    output logic       arready_o,
    output axi_id_t    rid_o,
    output axi_data_t  rdata_o,
    output logic [1:0] rresp_o,
    output logic       rlast_o,
    output logic       rvalid_o,
    input  logic       rready_i,
    input  logic       busy_i,
    input  logic       done_i,
    output logic       start_o,
    output logic       relu_o,
    output logic       swap_o,
    output run_len_t   run_len_o,
    output logic       epuint_o,
    buf_port_if.master in_bus,
    buf_port_if.master out_bus,
    buf_port_if.master wt_bus,
    buf_port_if.master bias_bus
);

    slave_state_t state_q, state_d;
    axi_id_t      id_q;
    axi_len_t     len_q;
    axi_len_t     beat_q;
    logic [7:0]   region_q;
    buf_addr_t    idx_q;
    logic         aw_hs, w_hs, ar_hs, r_hs;
    logic         access;
    logic [9:0]   ctrl_off;
    axi_data_t    ctrl_rdata, ctrl_rdata_q;
    logic         start_q, relu_q, swap_q, done_flag_q;
    run_len_t     run_len_q;

    // Both burst types run as INCR, so awburst_i and arburst_i are not decoded
    assign awready_o = (state_q == IDLE);
    assign arready_o = (state_q == IDLE) && !awvalid_i;
    assign wready_o  = (state_q == W_DATA);
    assign bvalid_o  = (state_q == B_RESP);
    assign rvalid_o  = (state_q == R_DATA);
    assign rlast_o   = (state_q == R_DATA) && (beat_q == len_q);
    assign bid_o     = id_q;
    assign rid_o     = id_q;
    assign bresp_o   = `AXI_RESP_OKAY;
    assign rresp_o   = `AXI_RESP_OKAY;

    assign aw_hs = awvalid_i && awready_o;
    assign ar_hs = arvalid_i && arready_o;
    assign w_hs  = wvalid_i && wready_o;
    assign r_hs  = rvalid_o && rready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (aw_hs) begin
                    state_d = W_DATA;
                end else if (ar_hs) begin
                    state_d = R_FETCH;
                end
            end
            W_DATA:  if (w_hs && wlast_i) state_d = B_RESP;
            B_RESP:  if (bready_i) state_d = IDLE;
            R_FETCH: state_d = R_DATA;
            R_DATA:  if (r_hs) state_d = rlast_o ? IDLE : R_FETCH;
            default: state_d = IDLE;
        endcase
    end

    // Burst context captured on the address handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            id_q     <= '0;
            len_q    <= '0;
            beat_q   <= '0;
            region_q <= '0;
            idx_q    <= '0;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                id_q     <= awid_i;
                region_q <= awaddr_i[31:24];
                idx_q    <= awaddr_i[`EPU_BUF_AW+1:2];
            end else if (ar_hs) begin
                id_q     <= arid_i;
                len_q    <= arlen_i;
                beat_q   <= '0;
                region_q <= araddr_i[31:24];
                idx_q    <= araddr_i[`EPU_BUF_AW+1:2];
            end else if (w_hs || r_hs) begin
                // Index wraps at the buffer end
                idx_q  <= idx_q + 1'b1;
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // One buffer access per write beat or per fetch cycle
    assign access = w_hs || (state_q == R_FETCH);

    assign in_bus.en     = access && (region_q == `EPU_REG_IN);
    assign in_bus.we     = (state_q == W_DATA);
    assign in_bus.be     = wstrb_i;
    assign in_bus.addr   = idx_q;
    assign in_bus.wdata  = wdata_i;

    assign out_bus.en    = access && (region_q == `EPU_REG_OUT);
    assign out_bus.we    = (state_q == W_DATA);
    assign out_bus.be    = wstrb_i;
    assign out_bus.addr  = idx_q;
    assign out_bus.wdata = wdata_i;

    assign wt_bus.en     = access && (region_q == `EPU_REG_WT);
    assign wt_bus.we     = (state_q == W_DATA);
    assign wt_bus.be     = wstrb_i;
    assign wt_bus.addr   = idx_q;
    assign wt_bus.wdata  = wdata_i;

    assign bias_bus.en    = access && (region_q == `EPU_REG_BIAS);
    assign bias_bus.we    = (state_q == W_DATA);
    assign bias_bus.be    = wstrb_i;
    assign bias_bus.addr  = idx_q;
    assign bias_bus.wdata = wdata_i;

    // Control registers, addressed by byte offset
    assign ctrl_off = {idx_q, 2'b00};

    always_comb begin
        case (ctrl_off)
            `EPU_CTRL_LEN:  ctrl_rdata = {{(32 - $bits(run_len_t)){1'b0}}, run_len_q};
            `EPU_CTRL_CMD:  ctrl_rdata = {29'b0, swap_q, relu_q, 1'b0};
            `EPU_CTRL_STAT: ctrl_rdata = {30'b0, done_flag_q, busy_i};
            default:        ctrl_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q      <= 1'b0;
            relu_q       <= 1'b0;
            swap_q       <= 1'b0;
            run_len_q    <= '0;
            done_flag_q  <= 1'b0;
            ctrl_rdata_q <= '0;
        end else begin
            start_q <= 1'b0;
            if (w_hs && region_q == `EPU_REG_CTRL) begin
                if (ctrl_off == `EPU_CTRL_LEN) begin
                    run_len_q <= wdata_i[`EPU_BUF_AW:0];
                end else if (ctrl_off == `EPU_CTRL_CMD && wdata_i[0]) begin
                    start_q <= 1'b1;
                    relu_q  <= wdata_i[1];
                    swap_q  <= wdata_i[2];
                end
            end
            // Held for the whole beat so rdata stays stable under back-pressure
            if (state_q == R_FETCH) begin
                ctrl_rdata_q <= ctrl_rdata;
            end
            if (start_q) begin
                done_flag_q <= 1'b0;
            end else if (done_i) begin
                done_flag_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (region_q)
            `EPU_REG_IN:   rdata_o = in_bus.rdata;
            `EPU_REG_OUT:  rdata_o = out_bus.rdata;
            `EPU_REG_WT:   rdata_o = wt_bus.rdata;
            `EPU_REG_BIAS: rdata_o = bias_bus.rdata;
            `EPU_REG_CTRL: rdata_o = ctrl_rdata_q;
            default:       rdata_o = '0;
        endcase
    end

    assign start_o   = start_q;
    assign relu_o    = relu_q;
    assign swap_o    = swap_q;
    assign run_len_o = run_len_q;
    assign epuint_o  = done_flag_q;

endmodule

// ==== hw/epu_buffer.sv ====
`include "epu_consts.svh"

module epu_buffer
    import epu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      busy_i,
    buf_port_if.slave bus_port,
    buf_port_if.slave eng_port
);

    axi_data_t mem [0:`EPU_BUF_DEPTH-1];
    axi_data_t rdata_q;
    logic      en;
    logic      we;
    axi_strb_t be;
    buf_addr_t addr;
    axi_data_t wdata;

    // Engine owns the single port for the whole run
    always_comb begin
        if (busy_i) begin
            en    = eng_port.en;
            we    = eng_port.we;
            be    = eng_port.be;
            addr  = eng_port.addr;
            wdata = eng_port.wdata;
        end else begin
            en    = bus_port.en;
            we    = bus_port.we;
            be    = bus_port.be;
            addr  = bus_port.addr;
            wdata = bus_port.wdata;
        end
    end

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int b = 0; b < $bits(axi_strb_t); b++) begin
                if (be[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Read word holds until the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (en && !we) begin
            rdata_q <= mem[addr];
        end
    end

    assign bus_port.rdata = rdata_q;
    assign eng_port.rdata = rdata_q;

endmodule

// ==== hw/mac_engine.sv ====
`include "epu_consts.svh"

module mac_engine
    import epu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  logic       relu_i,
    input  logic       swap_i,
    input  run_len_t   run_len_i,
    output logic       busy_o,
    output logic       done_o,
    buf_port_if.master in_eng,
    buf_port_if.master out_eng,
    buf_port_if.master wt_eng,
    buf_port_if.master bias_eng
);

    logic      busy_q;
    logic      done_q;
    logic      relu_q;
    logic      swap_q;
    logic      wr_pend_q;
    run_len_t  len_q;
    run_len_t  cnt_q;
    buf_addr_t wr_idx_q;
    buf_addr_t rd_idx;
    logic      rd_en;
    axi_data_t src_data;
    axi_data_t sum;
    axi_data_t result;

    // Read stage runs until every element has been fetched
    assign rd_en  = busy_q && (cnt_q != len_q);
    assign rd_idx = cnt_q[`EPU_BUF_AW-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            relu_q    <= 1'b0;
            swap_q    <= 1'b0;
            wr_pend_q <= 1'b0;
            len_q     <= '0;
            cnt_q     <= '0;
            wr_idx_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i && !busy_q) begin
                // Options are frozen for the run
                relu_q    <= relu_i;
                swap_q    <= swap_i;
                len_q     <= run_len_i;
                cnt_q     <= '0;
                wr_pend_q <= 1'b0;
                if (run_len_i == '0) begin
                    done_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                end
            end else if (busy_q) begin
                wr_pend_q <= rd_en;
                wr_idx_q  <= rd_idx;
                if (rd_en) begin
                    cnt_q <= cnt_q + 1'b1;
                end
                // Last write done, nothing left to fetch
                if (wr_pend_q && !rd_en) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Low 32 bits of the product are the same signed or unsigned
    assign src_data = swap_q ? out_eng.rdata : in_eng.rdata;
    assign sum      = src_data * wt_eng.rdata + bias_eng.rdata;
    assign result   = (relu_q && sum[31]) ? '0 : sum;

    // Source and destination trade places when swapped
    assign in_eng.en     = swap_q ? wr_pend_q : rd_en;
    assign in_eng.we     = swap_q;
    assign in_eng.be     = '1;
    assign in_eng.addr   = swap_q ? wr_idx_q : rd_idx;
    assign in_eng.wdata  = result;

    assign out_eng.en    = swap_q ? rd_en : wr_pend_q;
    assign out_eng.we    = !swap_q;
    assign out_eng.be    = '1;
    assign out_eng.addr  = swap_q ? rd_idx : wr_idx_q;
    assign out_eng.wdata = result;

    assign wt_eng.en      = rd_en;
    assign wt_eng.we      = 1'b0;
    assign wt_eng.be      = '0;
    assign wt_eng.addr    = rd_idx;
    assign wt_eng.wdata   = '0;

    assign bias_eng.en    = rd_en;
    assign bias_eng.we    = 1'b0;
    assign bias_eng.be    = '0;
    assign bias_eng.addr  = rd_idx;
    assign bias_eng.wdata = '0;

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

// ==== hw/epu_top.sv ====
module epu_top
    import epu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Write address
    input  axi_id_t   awid_i,
    input  axi_addr_t awaddr_i,
    input  axi_len_t  awlen_i,
    input  logic [1:0] awburst_i,
    input  logic      awvalid_i,
    output logic      awready_o,
    // Write data
    input  axi_data_t wdata_i,
    input  axi_strb_t wstrb_i,
    input  logic      wlast_i,
    input  logic      wvalid_i,
    output logic      wready_o,
    // Write response
    output axi_id_t   bid_o,
    output logic [1:0] bresp_o,
    output logic      bvalid_o,
    input  logic      bready_i,
    // Read address
    input  axi_id_t   arid_i,
    input  axi_addr_t araddr_i,
    input  axi_len_t  arlen_i,
    input  logic [1:0] arburst_i,
    input  logic      arvalid_i,
    output logic      arready_o,
    // Read data
    output axi_id_t   rid_o,
    output axi_data_t rdata_o,
    output logic [1:0] rresp_o,
    output logic      rlast_o,
    output logic      rvalid_o,
    input  logic      rready_i,
    output logic      epuint_o
);

    logic     start;
    logic     relu;
    logic     swap;
    run_len_t run_len;
    logic     busy;
    logic     done;

    // Host side of each buffer
    buf_port_if in_bus ();
    buf_port_if out_bus ();
    buf_port_if wt_bus ();
    buf_port_if bias_bus ();

    // Engine side of each buffer
    buf_port_if in_eng ();
    buf_port_if out_eng ();
    buf_port_if wt_eng ();
    buf_port_if bias_eng ();

    epu_axi_slave u_slave (
        .clk       (clk),
        .rst       (rst),
        .awid_i    (awid_i),
        .awaddr_i  (awaddr_i),
        .awlen_i   (awlen_i),
        .awburst_i (awburst_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wlast_i   (wlast_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bid_o     (bid_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .arid_i    (arid_i),
        .araddr_i  (araddr_i),
        .arlen_i   (arlen_i),
        .arburst_i (arburst_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rid_o     (rid_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rlast_o   (rlast_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .busy_i    (busy),
        .done_i    (done),
        .start_o   (start),
        .relu_o    (relu),
        .swap_o    (swap),
        .run_len_o (run_len),
        .epuint_o  (epuint_o),
        .in_bus    (in_bus),
        .out_bus   (out_bus),
        .wt_bus    (wt_bus),
        .bias_bus  (bias_bus)
    );

    epu_buffer u_in_buf (
        .clk      (clk),
        .rst      (rst),
        .busy_i   (busy),
        .bus_port (in_bus),
        .eng_port (in_eng)
    );

    epu_buffer u_out_buf (
        .clk      (clk),
        .rst      (rst),
        .busy_i   (busy),
        .bus_port (out_bus),
        .eng_port (out_eng)
    );

    epu_buffer u_wt_buf (
        .clk      (clk),
        .rst      (rst),
        .busy_i   (busy),
        .bus_port (wt_bus),
        .eng_port (wt_eng)
    );

    epu_buffer u_bias_buf (
        .clk      (clk),
        .rst      (rst),
        .busy_i   (busy),
        .bus_port (bias_bus),
        .eng_port (bias_eng)
    );

    mac_engine u_engine (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start),
        .relu_i    (relu),
        .swap_i    (swap),
        .run_len_i (run_len),
        .busy_o    (busy),
        .done_o    (done),
        .in_eng    (in_eng),
        .out_eng   (out_eng),
        .wt_eng    (wt_eng),
        .bias_eng  (bias_eng)
    );

endmodule

// ==== verification/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for the first 4 cycles
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/tb_epu.sv ====
`include "epu_consts.svh"

module tb_epu
    import epu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam axi_addr_t LEN_ADDR  = {`EPU_REG_CTRL, 14'h0, `EPU_CTRL_LEN};
    localparam axi_addr_t CMD_ADDR  = {`EPU_REG_CTRL, 14'h0, `EPU_CTRL_CMD};
    localparam axi_addr_t STAT_ADDR = {`EPU_REG_CTRL, 14'h0, `EPU_CTRL_STAT};
    // Done set, busy clear
    localparam axi_data_t STAT_DONE = 32'h0000_0002;

    logic       clk;
    logic       rst;
    axi_id_t    awid_i, arid_i, bid_o, rid_o;
    axi_addr_t  awaddr_i, araddr_i;
    axi_len_t   awlen_i, arlen_i;
    logic [1:0] awburst_i, arburst_i, bresp_o, rresp_o;
    logic       awvalid_i, awready_o, wlast_i, wvalid_i, wready_o;
    logic       bvalid_o, bready_i, arvalid_i, arready_o;
    logic       rlast_o, rvalid_o, rready_i, epuint_o;
    axi_data_t  wdata_i, rdata_o;
    axi_strb_t  wstrb_i;

    // Beat data of the current burst, write data or expected read data
    axi_data_t  beat_data [0:`EPU_BUF_DEPTH-1];
    axi_strb_t  beat_strb [0:`EPU_BUF_DEPTH-1];

    logic [7:0]  op_q [$];
    logic [31:0] arg_q [$];
    int          data_words = 0;
    int          run_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic        bp_on = 1'b0;
    integer      seed = 34147;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    epu_top UUT (
        .clk       (clk),
        .rst       (rst),
        .awid_i    (awid_i),
        .awaddr_i  (awaddr_i),
        .awlen_i   (awlen_i),
        .awburst_i (awburst_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wlast_i   (wlast_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bid_o     (bid_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .arid_i    (arid_i),
        .araddr_i  (araddr_i),
        .arlen_i   (arlen_i),
        .arburst_i (arburst_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rid_o     (rid_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rlast_o   (rlast_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .epuint_o  (epuint_o)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH %s: actual %h expected %h",
                                      name, actual, expected));
        end
    endtask

    // Ready level for the next cycle, random only under back-pressure
    task automatic pick_ready(output logic rdy);
        logic [31:0] r;
        r   = $random(seed);
        rdy = bp_on ? r[0] : 1'b1;
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_len_t len, input axi_id_t id);
        int   beat;
        logic rdy;
        @(posedge clk);
        awid_i    <= id;
        awaddr_i  <= addr;
        awlen_i   <= len;
        awburst_i <= 2'b01;
        awvalid_i <= 1'b1;
        do @(negedge clk); while (!awready_o);
        @(posedge clk);
        awvalid_i <= 1'b0;
        for (beat = 0; beat <= int'(len); beat++) begin
            wdata_i  <= beat_data[beat];
            wstrb_i  <= beat_strb[beat];
            wlast_i  <= (beat == int'(len));
            wvalid_i <= 1'b1;
            do @(negedge clk); while (!wready_o);
            @(posedge clk);
        end
        wvalid_i <= 1'b0;
        wlast_i  <= 1'b0;
        pick_ready(rdy);
        bready_i <= rdy;
        @(negedge clk);
        while (!(bvalid_o && bready_i)) begin
            @(posedge clk);
            pick_ready(rdy);
            bready_i <= rdy;
            @(negedge clk);
        end
        check_val("bid_o", 32'(bid_o), 32'(id));
        check_val("bresp_o", 32'(bresp_o), 32'(`AXI_RESP_OKAY));
        @(posedge clk);
        bready_i <= 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, input axi_len_t len, input axi_id_t id);
        int        beat;
        logic      rdy;
        logic      held;
        axi_data_t held_data;
        @(posedge clk);
        arid_i    <= id;
        araddr_i  <= addr;
        arlen_i   <= len;
        arburst_i <= 2'b01;
        arvalid_i <= 1'b1;
        do @(negedge clk); while (!arready_o);
        @(posedge clk);
        arvalid_i <= 1'b0;
        beat      = 0;
        held      = 1'b0;
        held_data = '0;
        while (beat <= int'(len)) begin
            pick_ready(rdy);
            rready_i <= rdy;
            @(negedge clk);
            if (rvalid_o) begin
                // A stalled beat must not change
                if (held) begin
                    check_val("rdata_o held", rdata_o, held_data);
                end
                if (rready_i) begin
                    check_val("rdata_o", rdata_o, beat_data[beat]);
                    check_val("rid_o", 32'(rid_o), 32'(id));
                    check_val("rresp_o", 32'(rresp_o), 32'(`AXI_RESP_OKAY));
                    check_val("rlast_o", 32'(rlast_o), 32'(beat == int'(len)));
                    beat++;
                    held = 1'b0;
                end else begin
                    held      = 1'b1;
                    held_data = rdata_o;
                end
            end
            @(posedge clk);
        end
        rready_i <= 1'b0;
    endtask

    task automatic run_engine(input logic [31:0] run_len, input logic [31:0] cmd);
        beat_data[0] = run_len;
        beat_strb[0] = 4'hf;
        axi_write(LEN_ADDR, 8'd0, 4'd0);
        beat_data[0] = cmd;
        axi_write(CMD_ADDR, 8'd0, 4'd0);
        // Start clears the interrupt of the previous run
        @(negedge clk);
        check_val("epuint_o after start", 32'(epuint_o), 32'd0);
        do @(negedge clk); while (!epuint_o);
        beat_data[0] = STAT_DONE;
        axi_read(STAT_ADDR, 8'd0, 4'd1);
    endtask

    task automatic load_tests();
        int          fd;
        int          code;
        int          ch;
        int          i;
        logic [63:0] tok;
        logic [31:0] word;
        logic [31:0] len;
        fd = $fopen("verification/epu_tests.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open verification/epu_tests.txt");
        end
        forever begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok == "#") begin
                do ch = $fgetc(fd); while (ch != 10 && ch != -1);
            end else if (tok == "W" || tok == "R") begin
                op_q.push_back(tok[7:0]);
                code = $fscanf(fd, "%h %h %h", word, len, ch);
                arg_q.push_back(word);
                arg_q.push_back(len);
                arg_q.push_back(32'(ch));
                for (i = 0; i <= int'(len); i++) begin
                    code = $fscanf(fd, "%h", word);
                    arg_q.push_back(word);
                    if (tok == "W") begin
                        code = $fscanf(fd, "%h", word);
                        arg_q.push_back(word);
                    end
                end
                data_words += int'(len) + 1;
            end else if (tok == "S") begin
                op_q.push_back(tok[7:0]);
                code = $fscanf(fd, "%h %h", word, len);
                arg_q.push_back(word);
                arg_q.push_back(len);
                run_cnt++;
            end else if (tok == "P") begin
                op_q.push_back(tok[7:0]);
            end else begin
                stop_with_error("unknown command in the test file");
            end
        end
        $fclose(fd);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_with_error("timeout, the tests did not finish in time");
        end
    end

    initial begin
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] len;
        logic [31:0] id;
        logic [31:0] word;
        int          i;
        awid_i    <= '0;
        awaddr_i  <= '0;
        awlen_i   <= '0;
        awburst_i <= 2'b01;
        awvalid_i <= 1'b0;
        wdata_i   <= '0;
        wstrb_i   <= '0;
        wlast_i   <= 1'b0;
        wvalid_i  <= 1'b0;
        bready_i  <= 1'b0;
        arid_i    <= '0;
        araddr_i  <= '0;
        arlen_i   <= '0;
        arburst_i <= 2'b01;
        arvalid_i <= 1'b0;
        rready_i  <= 1'b0;

        load_tests();
        cycle_limit = 10 * data_words + 300 * run_cnt + 100;

        @(negedge rst);
        @(negedge clk);
        check_val("bvalid_o", 32'(bvalid_o), 32'd0);
        check_val("rvalid_o", 32'(rvalid_o), 32'd0);
        check_val("wready_o", 32'(wready_o), 32'd0);
        check_val("epuint_o", 32'(epuint_o), 32'd0);
        // Idle slave with no write pending accepts either address
        check_val("awready_o", 32'(awready_o), 32'd1);
        check_val("arready_o", 32'(arready_o), 32'd1);

        while (op_q.size() > 0) begin
            op = op_q.pop_front();
            case (op)
                "W", "R": begin
                    addr = arg_q.pop_front();
                    len  = arg_q.pop_front();
                    id   = arg_q.pop_front();
                    for (i = 0; i <= int'(len); i++) begin
                        beat_data[i] = arg_q.pop_front();
                        if (op == "W") begin
                            word         = arg_q.pop_front();
                            beat_strb[i] = word[3:0];
                        end
                    end
                    if (op == "W") begin
                        axi_write(addr, len[7:0], id[3:0]);
                    end else begin
                        axi_read(addr, len[7:0], id[3:0]);
                    end
                end
                "S": begin
                    len  = arg_q.pop_front();
                    word = arg_q.pop_front();
                    run_engine(len, word);
                end
                default: begin
                    bp_on = !bp_on;
                end
            endcase
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+common
common/epu_pkg.sv
common/buf_port_if.sv
hw/epu_axi_slave.sv
hw/epu_buffer.sv
hw/mac_engine.sv
hw/epu_top.sv
verification/tb_clk_gen.sv
verification/tb_epu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f list.f --top-module tb_epu -o tb_epu_sim

# A failing run exits non-zero, so keep its output for the search below
sim_out=$(./obj_dir/tb_epu_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

// ==== verification/epu_tests.txt ====
# W addr len id then len+1 pairs of data and strobe | R addr len id then len+1 expected words
# S run_len command, waits for the interrupt | P toggles random back-pressure | all hex
# Idle status after reset
R 80000008 0 1 00000000
# Input buffer
W 50000000 3 2 00000003 f fffffffe f 00000007 f 00010000 f
R 50000000 3 3 00000003 fffffffe 00000007 00010000
# Weights, full words then byte merges
W 70000000 3 4 00000000 f 00000000 f ffffffff f 00000000 f
W 70000000 3 5 12345605 1 55660004 3 000000fd 1 00010000 4
R 70000000 3 6 00000005 00000004 fffffffd 00010000
# Bias, full words then byte merges from word 1
W 71000000 3 7 00000010 f 00000020 f 00000030 f 00000040 f
W 71000004 1 8 ffff01ff 2 80000000 8
R 71000000 3 9 00000010 00000120 80000030 00000040
# Plain run over 4 elements
S 4 1
R 60000000 3 a 0000001f 00000118 8000001b 00000040
# ReLU run clamps element 2
S 4 3
R 60000000 3 b 0000001f 00000118 00000000 00000040
# Swapped run over 3 elements reads out and writes in
W 60000000 3 c 00000002 f 00000003 f ffffffff f 00000010 f
S 3 5
R 50000000 3 d 0000001a 0000012c 80000033 00010000
R 60000000 3 e 00000002 00000003 ffffffff 00000010
# Random ready on R and B from here
P
R 70000000 3 f 00000005 00000004 fffffffd 00010000
R 71000000 3 1 00000010 00000120 80000030 00000040
W 90000000 1 2 deadbeef f 01234567 f
R 90000000 3 3 00000000 00000000 00000000 00000000
R 80000000 2 4 00000003 00000004 00000002
R 50000000 3 5 0000001a 0000012c 80000033 00010000
P
R 80000004 0 6 00000004
